/* vlog.f */
design/panel_pkg.sv
design/front_panel.sv
design/panel_console.sv
design/cpu_sequencer.sv
design/mem_arbiter.sv
design/core_memory.sv
design/panel_top.sv
bench/panel_checker.sv
bench/panel_tb.sv

/* bench/panel_tb.sv */
`default_nettype none

module panel_tb;

    localparam int debounce_bits = 4;
    localparam int field_bits    = 1;
    localparam int max_rows      = 32;
    localparam int row_budget    = 2 ** debounce_bits + 64;

    // switch codes of the stimulus table, step is continue with single step held
    localparam int sw_none  = 0;
    localparam int sw_clear = 1;
    localparam int sw_extd  = 2;
    localparam int sw_load  = 3;
    localparam int sw_dep   = 4;
    localparam int sw_exam  = 5;
    localparam int sw_cont  = 6;
    localparam int sw_step  = 7;

    localparam panel_pkg::state_t h0 = panel_pkg::st_h0;
    localparam panel_pkg::state_t hw = panel_pkg::st_hw;

    logic                            clk = 1'b0;
    logic                            reset;
    logic                            clear;
    logic                            extd_addr;
    logic                            addr_load;
    logic                            dep;
    logic                            exam;
    logic                            cont;
    logic                            sing_step;
    logic                            halt;
    logic [panel_pkg::word_bits-1:0] sr;
    logic                            sw_active;
    logic                            triggerd;
    logic [panel_pkg::page_bits-1:0] ma;
    logic [panel_pkg::word_bits-1:0] mb;
    logic [field_bits-1:0]           field;
    logic [panel_pkg::page_bits-1:0] pc;
    logic [panel_pkg::word_bits-1:0] ac;
    panel_pkg::state_t               state;
    logic                            run;

    logic                            check;
    logic [panel_pkg::page_bits-1:0] exp_ma;
    logic [panel_pkg::word_bits-1:0] exp_mb;
    logic [field_bits-1:0]           exp_field;
    logic [panel_pkg::word_bits-1:0] exp_ac;
    logic [panel_pkg::page_bits-1:0] exp_pc;
    panel_pkg::state_t               exp_state;
    logic [31:0]                     exp_triggers;
    logic [31:0]                     exp_runs;
    int                              value_errors;
    int                              other_failures = 0;

    int                              row_sw    [max_rows];
    logic [panel_pkg::word_bits-1:0] row_sr    [max_rows];
    int                              row_hold  [max_rows];
    int                              row_late  [max_rows];
    logic [panel_pkg::page_bits-1:0] row_ma    [max_rows];
    logic [panel_pkg::word_bits-1:0] row_mb    [max_rows];
    logic [field_bits-1:0]           row_field [max_rows];
    logic [panel_pkg::word_bits-1:0] row_ac    [max_rows];
    logic [panel_pkg::page_bits-1:0] row_pc    [max_rows];
    panel_pkg::state_t               row_state [max_rows];
    int                              n_rows = 0;

    always #2 clk = ~clk;

    panel_top #(
        .debounce_bits(debounce_bits),
        .field_bits   (field_bits)
    ) i_panel_top (
        .clk       (clk),
        .reset     (reset),
        .clear     (clear),
        .extd_addr (extd_addr),
        .addr_load (addr_load),
        .dep       (dep),
        .exam      (exam),
        .cont      (cont),
        .sing_step (sing_step),
        .halt      (halt),
        .sr        (sr),
        .sw_active (sw_active),
        .triggerd  (triggerd),
        .ma        (ma),
        .mb        (mb),
        .field     (field),
        .pc        (pc),
        .ac        (ac),
        .state     (state),
        .run       (run)
    );

    panel_checker #(
        .field_bits(field_bits)
    ) i_panel_checker (
        .clk          (clk),
        .reset        (reset),
        .check        (check),
        .ma           (ma),
        .mb           (mb),
        .field        (field),
        .ac           (ac),
        .pc           (pc),
        .state        (state),
        .triggerd     (triggerd),
        .run          (run),
        .exp_ma       (exp_ma),
        .exp_mb       (exp_mb),
        .exp_field    (exp_field),
        .exp_ac       (exp_ac),
        .exp_pc       (exp_pc),
        .exp_state    (exp_state),
        .exp_triggers (exp_triggers),
        .exp_runs     (exp_runs),
        .error_count  (value_errors)
    );

    function automatic logic [panel_pkg::word_bits-1:0] pick_word();
        logic [panel_pkg::word_bits-1:0] w;
        w = $urandom;
        // a data word must never be mistaken for the halt instruction
        if (w == panel_pkg::hlt_word)
            w = w ^ 12'o0001;
        return w;
    endfunction

    task automatic add_row(
        input int                sw,
        input int                sr_val,
        input int                hold,
        input int                late,
        input int                ma_val,
        input int                mb_val,
        input int                field_val,
        input int                ac_val,
        input int                pc_val,
        input panel_pkg::state_t state_val
    );
        row_sw[n_rows]    = sw;
        row_sr[n_rows]    = sr_val;
        row_hold[n_rows]  = hold;
        row_late[n_rows]  = late;
        row_ma[n_rows]    = ma_val;
        row_mb[n_rows]    = mb_val;
        row_field[n_rows] = field_val;
        row_ac[n_rows]    = ac_val;
        row_pc[n_rows]    = pc_val;
        row_state[n_rows] = state_val;
        n_rows++;
    endtask

    task automatic build_table();
        logic [panel_pkg::word_bits-1:0] w0;
        logic [panel_pkg::word_bits-1:0] w1;
        logic [panel_pkg::word_bits-1:0] w2;
        logic [panel_pkg::word_bits-1:0] w3;
        logic [panel_pkg::word_bits-1:0] s2;
        logic [panel_pkg::word_bits-1:0] s3;
        logic [panel_pkg::word_bits-1:0] hlt;
        w0  = pick_word();
        w1  = pick_word();
        w2  = pick_word();
        w3  = pick_word();
        hlt = panel_pkg::hlt_word;
        // the accumulator wraps at twelve bits
        s2  = w0 + w1;
        s3  = s2 + w2;
        // program in field 0 is three data words and a halt
        add_row(sw_load, 0, 2, sw_none, 0, 0, 0, 0, 0, h0);
        add_row(sw_dep, w0, 2, sw_none, 1, w0, 0, 0, 0, h0);
        add_row(sw_dep, w1, 2, sw_none, 2, w1, 0, 0, 0, h0);
        add_row(sw_dep, w2, 2, sw_none, 3, w2, 0, 0, 0, h0);
        add_row(sw_dep, hlt, 2, sw_none, 4, hlt, 0, 0, 0, h0);
        add_row(sw_load, 0, 2, sw_none, 0, hlt, 0, 0, 0, h0);
        add_row(sw_exam, 0, 2, sw_none, 1, w0, 0, 0, 0, h0);
        add_row(sw_exam, 0, 2, sw_none, 2, w1, 0, 0, 0, h0);
        add_row(sw_exam, 0, 2, sw_none, 3, w2, 0, 0, 0, h0);
        add_row(sw_exam, 0, 2, sw_none, 4, hlt, 0, 0, 0, h0);
        // full run from address 0 stops one past the halt
        add_row(sw_load, 0, 2, sw_none, 0, hlt, 0, 0, 0, h0);
        add_row(sw_cont, 0, 2, sw_none, 0, hlt, 0, s3, 4, h0);
        // a deposit pressed during the lockout must not store or move ma
        add_row(sw_clear, 12'o0017, 2, sw_dep, 0, hlt, 0, 0, 4, h0);
        add_row(sw_step, 0, 2, sw_none, 0, hlt, 0, w0, 1, hw);
        add_row(sw_step, 0, 2, sw_none, 0, hlt, 0, s2, 2, hw);
        add_row(sw_cont, 0, 2, sw_none, 0, hlt, 0, s3, 4, h0);
        add_row(sw_load, 4, 2, sw_clear, 4, hlt, 0, s3, 4, h0);
        // field 1 address 0, with the deposit held well into the lockout
        add_row(sw_extd, 1, 2, sw_none, 4, hlt, 1, s3, 4, h0);
        add_row(sw_load, 0, 2, sw_none, 0, hlt, 1, s3, 4, h0);
        add_row(sw_dep, w3, 12, sw_none, 1, w3, 1, s3, 4, h0);
        add_row(sw_extd, 0, 2, sw_none, 1, w3, 0, s3, 4, h0);
        add_row(sw_load, 0, 2, sw_none, 0, w3, 0, s3, 4, h0);
        add_row(sw_exam, 0, 2, sw_none, 1, w0, 0, s3, 4, h0);
        add_row(sw_extd, 1, 2, sw_none, 1, w0, 1, s3, 4, h0);
        add_row(sw_load, 0, 2, sw_none, 0, w0, 1, s3, 4, h0);
        add_row(sw_exam, 0, 2, sw_none, 1, w3, 1, s3, 4, h0);
    endtask

    task automatic set_switch(input int code, input logic level);
        case (code)
            sw_clear:
                clear = level;
            sw_extd:
                extd_addr = level;
            sw_load:
                addr_load = level;
            sw_dep:
                dep = level;
            sw_exam:
                exam = level;
            sw_cont, sw_step:
                cont = level;
            default:
                ;
        endcase
    endtask

    task automatic wait_until_idle(input int row, input bit with_run);
        int n;
        n = 0;
        while ((sw_active || (with_run && run)) && n < row_budget)
        begin
            @(negedge clk);
            n++;
        end
        if (sw_active || (with_run && run))
        begin
            $display("Row %0d: panel or cpu still busy after %0d cycles", row, n);
            other_failures++;
        end
    endtask

    initial
    begin
        void'($urandom(32'h5271));
        reset     = 1'b1;
        clear     = 1'b0;
        extd_addr = 1'b0;
        addr_load = 1'b0;
        dep       = 1'b0;
        exam      = 1'b0;
        cont      = 1'b0;
        sing_step = 1'b0;
        halt      = 1'b0;
        sr        = '0;
        check     = 1'b0;
        exp_ma    = '0;
        exp_mb    = '0;
        exp_field = '0;
        exp_ac    = '0;
        exp_pc    = '0;
        exp_state = h0;
        exp_triggers = 0;
        exp_runs     = 0;
        build_table();
        repeat (3) @(negedge clk);
        reset = 1'b0;

        for (int r = 0; r < n_rows; r++)
        begin
            sr = row_sr[r];
            if (row_sw[r] == sw_step)
                sing_step = 1'b1;
            set_switch(row_sw[r], 1'b1);
            repeat (row_hold[r]) @(negedge clk);
            set_switch(row_sw[r], 1'b0);
            // second switch arrives while the panel is still locked out
            if (row_late[r] != sw_none)
            begin
                set_switch(row_late[r], 1'b1);
                repeat (2) @(negedge clk);
                set_switch(row_late[r], 1'b0);
            end
            wait_until_idle(r, row_sw[r] == sw_cont || row_sw[r] == sw_step);
            sing_step    = 1'b0;
            exp_ma       = row_ma[r];
            exp_mb       = row_mb[r];
            exp_field    = row_field[r];
            exp_ac       = row_ac[r];
            exp_pc       = row_pc[r];
            exp_state    = row_state[r];
            exp_triggers = r + 1;
            // every continue or step row starts the cpu from a halt
            if (row_sw[r] == sw_cont || row_sw[r] == sw_step)
                exp_runs = exp_runs + 1;
            check        = 1'b1;
            @(negedge clk);
            check = 1'b0;
        end

        @(negedge clk);
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_failures);
        if (value_errors == 0 && other_failures == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // watchdog sized from the table length
    initial
    begin
        wait (n_rows > 0);
        repeat (n_rows * row_budget * 2) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not complete",
                 n_rows * row_budget * 2);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/panel_checker.sv */
`default_nettype none

module panel_checker #(
    parameter int field_bits = 1
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             check,
    input  wire  [panel_pkg::page_bits-1:0] ma,
    input  wire  [panel_pkg::word_bits-1:0] mb,
    input  wire  [field_bits-1:0]           field,
    input  wire  [panel_pkg::word_bits-1:0] ac,
    input  wire  [panel_pkg::page_bits-1:0] pc,
    input  wire  panel_pkg::state_t         state,
    input  wire                             triggerd,
    input  wire                             run,
    input  wire  [panel_pkg::page_bits-1:0] exp_ma,
    input  wire  [panel_pkg::word_bits-1:0] exp_mb,
    input  wire  [field_bits-1:0]           exp_field,
    input  wire  [panel_pkg::word_bits-1:0] exp_ac,
    input  wire  [panel_pkg::page_bits-1:0] exp_pc,
    input  wire  panel_pkg::state_t         exp_state,
    input  wire  [31:0]                     exp_triggers,
    input  wire  [31:0]                     exp_runs,
    output int                              error_count
);

    logic triggerd_q;
    int   trigger_count;
    logic run_q;
    int   run_count;

    task automatic compare_value(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected)
        begin
            $display("Error at time %0t: %s is %0o, expected %0o", $time, name, actual, expected);
            error_count++;
        end
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            error_count = 0;
            trigger_count <= 0;
            triggerd_q    <= 1'b0;
            run_count     <= 0;
            run_q         <= 1'b0;
        end
        else
        begin
            triggerd_q <= triggerd;
            run_q      <= run;
            // every accepted operator action shows up as exactly one trigger
            if (triggerd && !triggerd_q)
                trigger_count <= trigger_count + 1;
            // each continue from a halt starts the cpu running once
            if (run && !run_q)
                run_count <= run_count + 1;
            if (check)
            begin
                compare_value("ma", ma, exp_ma);
                compare_value("mb", mb, exp_mb);
                compare_value("field", field, exp_field);
                compare_value("ac", ac, exp_ac);
                compare_value("pc", pc, exp_pc);
                compare_value("state", state, exp_state);
                compare_value("trigger count", trigger_count, exp_triggers);
                compare_value("run count", run_count, exp_runs);
            end
        end
    end

endmodule

`default_nettype wire

/* design/panel_top.sv */
`default_nettype none

module panel_top #(
    parameter int debounce_bits = 4,
    parameter int field_bits    = 1
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             clear,
    input  wire                             extd_addr,
    input  wire                             addr_load,
    input  wire                             dep,
    input  wire                             exam,
    input  wire                             cont,
    input  wire                             sing_step,
    input  wire                             halt,
    input  wire  [panel_pkg::word_bits-1:0] sr,
    output logic                            sw_active,
    output logic                            triggerd,
    output logic [panel_pkg::page_bits-1:0] ma,
    output logic [panel_pkg::word_bits-1:0] mb,
    output logic [field_bits-1:0]           field,
    output logic [panel_pkg::page_bits-1:0] pc,
    output logic [panel_pkg::word_bits-1:0] ac,
    output panel_pkg::state_t               state,
    output logic                            run
);

    localparam int addr_bits = field_bits + panel_pkg::page_bits;

    logic                            cleard;
    logic                            extd_addrd;
    logic                            addr_loadd;
    logic                            depd;
    logic                            examd;
    logic                            contd;
    logic                            con_req;
    logic                            con_we;
    logic                            con_gnt;
    logic                            cpu_req;
    logic                            cpu_gnt;
    logic                            mem_we;
    logic [addr_bits-1:0]            con_addr;
    logic [addr_bits-1:0]            cpu_addr;
    logic [addr_bits-1:0]            mem_addr;
    logic [panel_pkg::word_bits-1:0] con_wdata;
    logic [panel_pkg::word_bits-1:0] mem_wdata;
    logic [panel_pkg::word_bits-1:0] mem_rdata;

    front_panel #(
        .debounce_bits(debounce_bits)
    ) i_front_panel (
        .clk        (clk),
        .reset      (reset),
        .state      (state),
        .clear      (clear),
        .extd_addr  (extd_addr),
        .addr_load  (addr_load),
        .dep        (dep),
        .exam       (exam),
        .cont       (cont),
        .sing_step  (sing_step),
        .halt       (halt),
        .sw_active  (sw_active),
        .triggerd   (triggerd),
        .cleard     (cleard),
        .extd_addrd (extd_addrd),
        .addr_loadd (addr_loadd),
        .depd       (depd),
        .examd      (examd),
        .contd      (contd)
    );

    panel_console #(
        .field_bits(field_bits)
    ) i_panel_console (
        .clk        (clk),
        .reset      (reset),
        .sr         (sr),
        .addr_loadd (addr_loadd),
        .depd       (depd),
        .examd      (examd),
        .extd_addrd (extd_addrd),
        .ma         (ma),
        .field      (field),
        .mb         (mb),
        .con_req    (con_req),
        .con_we     (con_we),
        .con_addr   (con_addr),
        .con_wdata  (con_wdata),
        .con_gnt    (con_gnt),
        .mem_rdata  (mem_rdata)
    );

    // the console address registers give the cpu its start address
    cpu_sequencer #(
        .field_bits(field_bits)
    ) i_cpu_sequencer (
        .clk         (clk),
        .reset       (reset),
        .start_addr  (ma),
        .start_field (field),
        .contd       (contd),
        .cleard      (cleard),
        .sing_step   (sing_step),
        .halt        (halt),
        .state       (state),
        .pc          (pc),
        .ac          (ac),
        .run         (run),
        .cpu_req     (cpu_req),
        .cpu_addr    (cpu_addr),
        .cpu_gnt     (cpu_gnt),
        .mem_rdata   (mem_rdata)
    );

    mem_arbiter #(
        .field_bits(field_bits)
    ) i_mem_arbiter (
        .con_req   (con_req),
        .con_we    (con_we),
        .con_addr  (con_addr),
        .con_wdata (con_wdata),
        .con_gnt   (con_gnt),
        .cpu_req   (cpu_req),
        .cpu_addr  (cpu_addr),
        .cpu_gnt   (cpu_gnt),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    core_memory #(
        .field_bits(field_bits)
    ) i_core_memory (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* design/core_memory.sv */
`default_nettype none

module core_memory #(
    parameter int field_bits = 1
) (
    input  wire                                      clk,
    input  wire                                      mem_we,
    input  wire  [field_bits+panel_pkg::page_bits-1:0] mem_addr,
    input  wire  [panel_pkg::word_bits-1:0]          mem_wdata,
    output logic [panel_pkg::word_bits-1:0]          mem_rdata
);

    localparam int depth = 2 ** (field_bits + panel_pkg::page_bits);

    logic [panel_pkg::word_bits-1:0] mem [0:depth-1];

    // a write returns the old word on the read port in the same cycle
    always_ff @(posedge clk)
    begin
        if (mem_we)
            mem[mem_addr] <= mem_wdata;
        mem_rdata <= mem[mem_addr];
    end

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
`default_nettype none

module mem_arbiter #(
    parameter int field_bits = 1
) (
    input  wire                                      con_req,
    input  wire                                      con_we,
    input  wire  [field_bits+panel_pkg::page_bits-1:0] con_addr,
    input  wire  [panel_pkg::word_bits-1:0]          con_wdata,
    output logic                                     con_gnt,
    input  wire                                      cpu_req,
    input  wire  [field_bits+panel_pkg::page_bits-1:0] cpu_addr,
    output logic                                     cpu_gnt,
    output logic                                     mem_we,
    output logic [field_bits+panel_pkg::page_bits-1:0] mem_addr,
    output logic [panel_pkg::word_bits-1:0]          mem_wdata
);

    // the console always wins, the cpu only gets an idle cycle
    assign con_gnt = con_req;
    assign cpu_gnt = cpu_req && !con_req;

    // the cpu only reads so only the console can write
    assign mem_we    = con_req && con_we;
    assign mem_addr  = con_req ? con_addr : cpu_addr;
    assign mem_wdata = con_wdata;

endmodule

`default_nettype wire

/* design/cpu_sequencer.sv */
`default_nettype none

module cpu_sequencer #(
    parameter int field_bits = 1
) (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire  [panel_pkg::page_bits-1:0]          start_addr,
    input  wire  [field_bits-1:0]                    start_field,
    input  wire                                      contd,
    input  wire                                      cleard,
    input  wire                                      sing_step,
    input  wire                                      halt,
    output panel_pkg::state_t                        state,
    output logic [panel_pkg::page_bits-1:0]          pc,
    output logic [panel_pkg::word_bits-1:0]          ac,
    output logic                                     run,
    output logic                                     cpu_req,
    output logic [field_bits+panel_pkg::page_bits-1:0] cpu_addr,
    input  wire                                      cpu_gnt,
    input  wire  [panel_pkg::word_bits-1:0]          mem_rdata
);

    logic                           contd_q;
    logic                           cleard_q;
    logic                           cont_go;
    logic                           clear_go;
    logic                           halted;
    logic                           step_more;
    logic [field_bits-1:0]          pc_field;
    logic [panel_pkg::word_bits-1:0] ir;

    assign cont_go  = contd && !contd_q;
    assign clear_go = cleard && !cleard_q;

    assign halted   = (state == panel_pkg::st_h0) || (state == panel_pkg::st_hw);
    assign run      = !halted;

    // fetch holds the request until the arbiter grants it
    assign cpu_req  = (state == panel_pkg::st_f0);
    assign cpu_addr = {pc_field, pc};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            contd_q   <= 1'b0;
            cleard_q  <= 1'b0;
            state     <= panel_pkg::st_h0;
            pc        <= '0;
            pc_field  <= '0;
            ac        <= '0;
            step_more <= 1'b0;
        end
        else
        begin
            contd_q  <= contd;
            cleard_q <= cleard;

            case (state)
                panel_pkg::st_h0, panel_pkg::st_hw:
                begin
                    if (clear_go)
                        ac <= '0;
                    if (cont_go)
                    begin
                        // after a halt instruction the program restarts at the console
                        // address, a switch halt resumes where it stopped
                        if (state == panel_pkg::st_h0)
                        begin
                            pc       <= start_addr;
                            pc_field <= start_field;
                        end
                        state <= panel_pkg::st_f0;
                    end
                end
                panel_pkg::st_f0:
                begin
                    if (cpu_gnt)
                        state <= panel_pkg::st_d0;
                end
                panel_pkg::st_d0:
                begin
                    // read data belongs to the grant of the previous cycle
                    ir    <= mem_rdata;
                    state <= panel_pkg::st_e0;
                end
                panel_pkg::st_e0:
                begin
                    pc        <= pc + 1'b1;
                    step_more <= 1'b0;
                    if (ir == panel_pkg::hlt_word)
                        state <= panel_pkg::st_h0;
                    else
                    begin
                        ac <= ac + ir;
                        if (step_more)
                            state <= panel_pkg::st_f0;
                        else if (halt || sing_step)
                            state <= panel_pkg::st_hw;
                        else
                            state <= panel_pkg::st_f0;
                    end
                end
                default:
                    state <= panel_pkg::st_h0;
            endcase

            // a step requested mid instruction lets one more instruction through
            if (cont_go && !halted && sing_step)
                step_more <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/panel_console.sv */
`default_nettype none

module panel_console #(
    parameter int field_bits = 1
) (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire  [panel_pkg::word_bits-1:0]          sr,
    input  wire                                      addr_loadd,
    input  wire                                      depd,
    input  wire                                      examd,
    input  wire                                      extd_addrd,
    output logic [panel_pkg::page_bits-1:0]          ma,
    output logic [field_bits-1:0]                    field,
    output logic [panel_pkg::word_bits-1:0]          mb,
    output logic                                     con_req,
    output logic                                     con_we,
    output logic [field_bits+panel_pkg::page_bits-1:0] con_addr,
    output logic [panel_pkg::word_bits-1:0]          con_wdata,
    input  wire                                      con_gnt,
    input  wire  [panel_pkg::word_bits-1:0]          mem_rdata
);

    logic addr_loadd_q;
    logic depd_q;
    logic examd_q;
    logic extd_addrd_q;
    logic addr_load_go;
    logic dep_go;
    logic exam_go;
    logic extd_addr_go;
    logic rd_pending;

    // each switch pulse lasts several cycles, only its first cycle counts
    assign addr_load_go = addr_loadd && !addr_loadd_q;
    assign dep_go       = depd && !depd_q;
    assign exam_go      = examd && !examd_q;
    assign extd_addr_go = extd_addrd && !extd_addrd_q;

    assign con_addr  = {field, ma};
    assign con_wdata = mb;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            addr_loadd_q <= 1'b0;
            depd_q       <= 1'b0;
            examd_q      <= 1'b0;
            extd_addrd_q <= 1'b0;
            con_req      <= 1'b0;
            con_we       <= 1'b0;
            rd_pending   <= 1'b0;
            ma           <= '0;
            field        <= '0;
            mb           <= '0;
        end
        else
        begin
            addr_loadd_q <= addr_loadd;
            depd_q       <= depd;
            examd_q      <= examd;
            extd_addrd_q <= extd_addrd;

            if (addr_load_go)
                ma <= sr;
            if (extd_addr_go)
                field <= sr[field_bits-1:0];

            // deposit goes through mb so the lamps show the stored word
            if (dep_go)
            begin
                mb      <= sr;
                con_req <= 1'b1;
                con_we  <= 1'b1;
            end
            else if (exam_go)
            begin
                con_req <= 1'b1;
                con_we  <= 1'b0;
            end

            // memory took the address in the grant cycle so ma may move on
            if (con_req && con_gnt)
            begin
                con_req    <= 1'b0;
                ma         <= ma + 1'b1;
                rd_pending <= !con_we;
            end
            else
            begin
                rd_pending <= 1'b0;
            end

            if (rd_pending)
                mb <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* design/front_panel.sv */
`default_nettype none

module front_panel #(
    parameter int debounce_bits = 4
) (
    input  wire               clk,
    input  wire               reset,
    input  wire panel_pkg::state_t state,
    input  wire               clear,
    input  wire               extd_addr,
    input  wire               addr_load,
    input  wire               dep,
    input  wire               exam,
    input  wire               cont,
    input  wire               sing_step,
    input  wire               halt,
    output logic              sw_active,
    output logic              triggerd,
    output logic              cleard,
    output logic              extd_addrd,
    output logic              addr_loadd,
    output logic              depd,
    output logic              examd,
    output logic              contd
);

    typedef enum logic [2:0] {
        s_latch,
        s_wait,
        s_trig1,
        s_trig2,
        s_trig3,
        s_delay,
        s_reenable
    } trig_state_t;

    trig_state_t            trig_state;
    logic [5:0]             switch_latch;
    logic [6:0]             switch_pulse;
    logic [debounce_bits:0] lock_cnt;
    logic                   lockout;
    logic                   halted;
    logic                   may_fire;

    assign {triggerd, cleard, extd_addrd, addr_loadd, depd, examd, contd} = switch_pulse;

    assign halted = (state == panel_pkg::st_h0) || (state == panel_pkg::st_hw);

    // while the machine runs only a continue in single step mode gets through
    assign may_fire = halted || (switch_latch[0] && sing_step);

    // the halt level is shown as a busy panel so the operator waits
    assign sw_active = lockout || halt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            trig_state   <= s_latch;
            switch_latch <= '0;
            switch_pulse <= '0;
            lock_cnt     <= '0;
            lockout      <= 1'b0;
        end
        else
        begin
            case (trig_state)
                s_latch:
                begin
                    switch_latch <= switch_latch |
                                    {clear, extd_addr, addr_load, dep, exam, cont};
                    if (switch_latch != '0)
                    begin
                        trig_state <= s_wait;
                        lockout    <= 1'b1;
                    end
                end
                s_wait:
                begin
                    // hold the latched switches until the major state allows them
                    if (may_fire)
                    begin
                        trig_state   <= s_trig1;
                        switch_pulse <= {1'b1, switch_latch};
                        switch_latch <= '0;
                    end
                end
                s_trig1:
                    trig_state <= s_trig2;
                s_trig2:
                    trig_state <= s_trig3;
                s_trig3:
                    trig_state <= s_delay;
                s_delay:
                begin
                    // pulses end after the first delay cycle, lockout keeps going
                    switch_pulse <= '0;
                    if (lock_cnt[debounce_bits])
                        trig_state <= s_reenable;
                end
                s_reenable:
                begin
                    lockout    <= 1'b0;
                    trig_state <= s_latch;
                end
                default:
                    trig_state <= s_latch;
            endcase

            // the lockout counter restarts with every trigger
            if (trig_state == s_trig1)
                lock_cnt <= '0;
            else
                lock_cnt <= lock_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/panel_pkg.sv */
`default_nettype none

package panel_pkg;

    // data word and the address within one memory field
    localparam int word_bits = 12;
    localparam int page_bits = 12;

    // major states of the cpu, one hot so the panel lamps can be driven directly
    typedef enum logic [4:0] {
        st_f0 = 5'b00001,
        st_d0 = 5'b00010,
        st_e0 = 5'b00100,
        st_h0 = 5'b01000,
        st_hw = 5'b10000
    } state_t;

    // the only decoded instruction, everything else is added to the accumulator
    localparam logic [word_bits-1:0] hlt_word = 12'o7402;

endpackage

`default_nettype wire
